/* Makefile */
TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP       = zombieRenderTb
FILELIST  = verilog.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "simulation ended without a result"; exit 1; fi

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* dv/zombieRenderTb.sv */
module zombieRenderTb
  import videoPkg::*;
  import spritePkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int H_ACTIVE = 64;
  localparam int H_FRONT = 4;
  localparam int H_SYNC = 8;
  localparam int H_BACK = 4;
  localparam int V_ACTIVE = 48;
  localparam int V_FRONT = 2;
  localparam int V_SYNC = 2;
  localparam int V_BACK = 2;
  localparam int NUM_ZOMBIES = 3;
  localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int FRAME_LEN = H_TOTAL * V_TOTAL;
  localparam int TEST_FRAMES = 16;                    // upper bound over all tests.
  localparam int CYCLE_LIMIT = (TEST_FRAMES + 1) * FRAME_LEN;
  localparam zombieT OFF_SCREEN = '{posX: 10'd600, posY: 10'd600, face: FACE_UP};

  logic Clk = 1'b0;
  logic rst;
  zombieT [NUM_ZOMBIES-1:0] zombies;
  logic spriteWe;
  spriteAddrT spriteWrAddr;
  rgbT spriteWrData;
  rgbT vgaRgb;
  syncT vgaSync;

  rgbT shadowMem [4096];
  logic [31:0] lfsr = 32'h7b62_be1e;

  // model of the two pipeline stages behind the raster position
  int tbX = 0;
  int tbY = 0;
  logic s1Hit = 1'b0;
  rgbT s1Color = RGB_BLACK;
  syncT s1Sync = SYNC_IDLE;
  rgbT expRgb = RGB_BLACK;
  syncT expSync = SYNC_IDLE;
  int hitCount = 0;
  int visibleCount = 0;
  int cycles = 0;

  zombieRenderTop #(
    .H_ACTIVE(H_ACTIVE),
    .H_FRONT(H_FRONT),
    .H_SYNC(H_SYNC),
    .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE),
    .V_FRONT(V_FRONT),
    .V_SYNC(V_SYNC),
    .V_BACK(V_BACK),
    .NUM_ZOMBIES(NUM_ZOMBIES)
  ) i_dut (
    .Clk(Clk),
    .rst(rst),
    .zombies(zombies),
    .spriteWe(spriteWe),
    .spriteWrAddr(spriteWrAddr),
    .spriteWrData(spriteWrData),
    .vgaRgb(vgaRgb),
    .vgaSync(vgaSync)
  );

  always #10 Clk = ~Clk;

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("[ERROR] %s: got %h, expected %h at x %0d y %0d", name, got, exp, tbX, tbY);
      $display("RESULT: FAIL");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++)
    begin
      value = {value[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return value;
  endfunction

  function automatic zombieT makeZombie(input int x, input int y, input faceT face);
    zombieT z;
    z.posX = coordT'(x);
    z.posY = coordT'(y);
    z.face = face;
    return z;
  endfunction

  function automatic syncT syncAt(input int x, input int y);
    syncT s;
    s.hSync = !((x >= H_ACTIVE + H_FRONT) && (x < H_ACTIVE + H_FRONT + H_SYNC));
    s.vSync = !((y >= V_ACTIVE + V_FRONT) && (y < V_ACTIVE + V_FRONT + V_SYNC));
    s.videoOn = (x < H_ACTIVE) && (y < V_ACTIVE);
    return s;
  endfunction

  // first zombie whose box holds the pixel gives the colour
  task automatic lookupSprite(input int x, input int y, output logic hit, output rgbT color);
    int px;
    int py;
    hit = 1'b0;
    color = RGB_BLACK;
    for (int i = 0; i < NUM_ZOMBIES; i++)
    begin
      px = int'(zombies[i].posX);
      py = int'(zombies[i].posY);
      if (!hit && (x >= px) && (x < px + SPRITE_SIZE) && (y >= py) && (y < py + SPRITE_SIZE))
      begin
        hit = 1'b1;
        color = shadowMem[{zombies[i].face, 5'(y - py), 5'(x - px)}];
      end
    end
  endtask

  always @(posedge Clk)
  begin
    cycles++;
    if (cycles > CYCLE_LIMIT)
    begin
      $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("RESULT: FAIL");
      $fatal(1, "simulation stopped by timeout");
    end
  end

  // compares every output cycle, then steps the model to the next edge
  always @(negedge Clk)
  begin
    check("vgaRgb", 32'(vgaRgb), 32'(expRgb));
    check("vgaSync.hSync", 32'(vgaSync.hSync), 32'(expSync.hSync));
    check("vgaSync.vSync", 32'(vgaSync.vSync), 32'(expSync.vSync));
    check("vgaSync.videoOn", 32'(vgaSync.videoOn), 32'(expSync.videoOn));
    if (rst)
    begin
      expRgb = RGB_BLACK;
      expSync = SYNC_IDLE;
      s1Hit = 1'b0;
      s1Sync = SYNC_IDLE;
      tbX = 0;
      tbY = 0;
    end
    else
    begin
      expRgb = !s1Sync.videoOn ? RGB_BLACK : (s1Hit ? s1Color : BG_COLOR);
      expSync = s1Sync;
      visibleCount += int'(vgaSync.videoOn);
      hitCount += int'(s1Sync.videoOn && s1Hit);
      s1Sync = syncAt(tbX, tbY);
      lookupSprite(tbX, tbY, s1Hit, s1Color);
      if (tbX == H_TOTAL - 1)
      begin
        tbX = 0;
        tbY = (tbY == V_TOTAL - 1) ? 0 : tbY + 1;
      end
      else
      begin
        tbX = tbX + 1;
      end
    end
    if (spriteWe)
    begin
      shadowMem[spriteWrAddr] = spriteWrData;     // read above still saw the old word.
    end
  end

  task automatic writeWord(input spriteAddrT addr, input rgbT data);
    @(posedge Clk);
    spriteWe <= 1'b1;
    spriteWrAddr <= addr;
    spriteWrData <= data;
  endtask

  task automatic endWrites();
    @(posedge Clk);
    spriteWe <= 1'b0;
  endtask

  task automatic waitBlank();
    @(posedge Clk);
    while (!((tbX == 0) && (tbY == V_ACTIVE)))
    begin
      @(posedge Clk);
    end
  endtask

  task automatic runFrame(input int expHits);
    hitCount = 0;
    visibleCount = 0;
    waitBlank();
    check("visible pixels", 32'(visibleCount), 32'(H_ACTIVE * V_ACTIVE));
    check("zombie pixels", 32'(hitCount), 32'(expHits));
  endtask

  task automatic afterResetTest();
    repeat (2)
    begin
      @(negedge Clk);
      check("vgaSync", 32'(vgaSync), 32'(SYNC_IDLE));
      check("vgaRgb", 32'(vgaRgb), 32'(RGB_BLACK));
    end
    @(negedge Clk);
    check("vgaSync.videoOn", 32'(vgaSync.videoOn), 32'd1);  // pixel (0,0) after the fill.
    check("vgaRgb", 32'(vgaRgb), 32'(BG_COLOR));
  endtask

  task automatic emptyScreenTest();
    waitBlank();
    zombies <= {NUM_ZOMBIES{OFF_SCREEN}};
    runFrame(0);
  endtask

  task automatic facingTest();
    for (int a = 0; a < 4096; a++)
    begin
      writeWord(spriteAddrT'(a), rgbT'(randBits(24)));
    end
    endWrites();
    waitBlank();
    for (int f = 0; f < 4; f++)
    begin
      zombies <= {OFF_SCREEN, OFF_SCREEN, makeZombie(16, 8, faceT'(f))};
      runFrame(SPRITE_SIZE * SPRITE_SIZE);
    end
  endtask

  task automatic overlapTest();
    waitBlank();
    zombies <= {makeZombie(26, 14, FACE_LEFT), makeZombie(20, 10, FACE_RIGHT),
                makeZombie(10, 5, FACE_UP)};
    runFrame(1750);                               // union of the three boxes.
  endtask

  task automatic edgeTest();
    waitBlank();
    zombies <= {OFF_SCREEN, makeZombie(4, 2, FACE_DOWN), makeZombie(48, 30, FACE_RIGHT)};
    runFrame(SPRITE_SIZE * SPRITE_SIZE + 16 * 18);  // 16 columns and 18 rows stay visible.
  endtask

  task automatic rewriteTest();
    waitBlank();
    zombies <= {OFF_SCREEN, OFF_SCREEN, makeZombie(16, 8, FACE_DOWN)};
    while (tbY != 20)
    begin
      @(posedge Clk);
    end
    // rows 10 to 13 of the down image change while row 12 is drawn
    for (int a = 0; a < 4 * SPRITE_SIZE; a++)
    begin
      writeWord({FACE_DOWN, 10'(10 * SPRITE_SIZE + a)}, rgbT'(randBits(24)));
    end
    endWrites();
    waitBlank();
    runFrame(SPRITE_SIZE * SPRITE_SIZE);
  endtask

  initial
  begin
    rst = 1'b1;
    zombies = {NUM_ZOMBIES{OFF_SCREEN}};
    spriteWe = 1'b0;
    spriteWrAddr = '0;
    spriteWrData = '0;
    repeat (2) @(posedge Clk);
    rst <= 1'b0;
    afterResetTest();
    emptyScreenTest();
    facingTest();
    overlapTest();
    edgeTest();
    rewriteTest();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* source/pixelColorMapper.sv */
module pixelColorMapper
  import videoPkg::*;
(
  input logic Clk,
  input logic rst,
  input rgbT spriteColor,
  input logic isZombie,
  input syncT tableSync,
  output rgbT vgaRgb,
  output syncT vgaSync
);

  rgbT pixelColor;

  always_comb
  begin
    if (!tableSync.videoOn)
    begin
      pixelColor = RGB_BLACK;                   // blanking.
    end
    else if (isZombie)
    begin
      pixelColor = spriteColor;
    end
    else
    begin
      pixelColor = BG_COLOR;
    end
  end

  always_ff @(posedge Clk)
  begin
    if (rst)
    begin
      vgaRgb <= RGB_BLACK;
      vgaSync <= SYNC_IDLE;
    end
    else
    begin
      vgaRgb <= pixelColor;
      vgaSync <= tableSync;                     // keeps sync in step with colour.
    end
  end

  // a monitor sees no colour during blanking, reset included
  blankBlackA: assert property (@(posedge Clk)
    !vgaSync.videoOn |-> (vgaRgb == RGB_BLACK));

endmodule

/* source/spritePkg.sv */
package spritePkg;

  import videoPkg::*;

  localparam int SPRITE_SIZE = 32;            // edge of one sprite in pixels.

  typedef logic [1:0] faceT;                  // which way a zombie looks.

  localparam faceT FACE_UP = 2'd0;
  localparam faceT FACE_RIGHT = 2'd1;
  localparam faceT FACE_DOWN = 2'd2;
  localparam faceT FACE_LEFT = 2'd3;

  typedef logic [4:0] spriteOffT;             // row or column inside a sprite.

  // one zombie on screen, top left corner and facing
  typedef struct packed {
    coordT posX;
    coordT posY;
    faceT face;
  } zombieT;

  // facing picks the image, then row, then column
  typedef logic [11:0] spriteAddrT;

endpackage

/* source/spriteRam.sv */
module spriteRam
  import videoPkg::*;
  import spritePkg::*;
(
  input logic Clk,
  input logic we,
  input spriteAddrT wrAddr,
  input rgbT wrData,
  input spriteAddrT rdAddr,
  output rgbT rdData
);

  // four facing images of SPRITE_SIZE x SPRITE_SIZE words each
  localparam int DEPTH = 2 ** $bits(spriteAddrT);

  rgbT mem [DEPTH];

  always_ff @(posedge Clk)
  begin
    if (we)
    begin
      mem[wrAddr] <= wrData;
    end
    rdData <= mem[rdAddr];                       // same-cycle write gives the old word.
  end

endmodule

/* source/vgaTimer.sv */
module vgaTimer
  import videoPkg::*;
#(
  parameter int H_ACTIVE = 640,
  parameter int H_FRONT = 16,
  parameter int H_SYNC = 96,
  parameter int H_BACK = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FRONT = 10,
  parameter int V_SYNC = 2,
  parameter int V_BACK = 33
)
(
  input logic Clk,
  input logic rst,
  output pixelPosT pixelPos,
  output syncT rawSync
);

  localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
  localparam int H_SYNC_END = H_SYNC_START + H_SYNC;
  localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
  localparam int V_SYNC_END = V_SYNC_START + V_SYNC;

  coordT hCount;
  coordT vCount;

  always_ff @(posedge Clk)
  begin
    if (rst)
    begin
      hCount <= '0;
      vCount <= '0;
    end
    else if (hCount == coordT'(H_TOTAL - 1))
    begin
      hCount <= '0;                               // end of line.
      if (vCount == coordT'(V_TOTAL - 1))
      begin
        vCount <= '0;                             // end of frame.
      end
      else
      begin
        vCount <= vCount + 1'b1;
      end
    end
    else
    begin
      hCount <= hCount + 1'b1;
    end
  end

  always_comb
  begin
    pixelPos.drawX = hCount;
    pixelPos.drawY = vCount;
    rawSync.hSync = !((hCount >= coordT'(H_SYNC_START)) && (hCount < coordT'(H_SYNC_END)));
    rawSync.vSync = !((vCount >= coordT'(V_SYNC_START)) && (vCount < coordT'(V_SYNC_END)));
    rawSync.videoOn = (hCount < coordT'(H_ACTIVE)) && (vCount < coordT'(V_ACTIVE));
  end

  // frame totals must fit the coordinate and the counters wrap in time
  counterRangeA: assert property (@(posedge Clk) disable iff (rst)
    (hCount < coordT'(H_TOTAL)) && (vCount < coordT'(V_TOTAL)));

endmodule

/* source/videoPkg.sv */
package videoPkg;

  typedef logic [9:0] coordT;   // screen coordinate, x or y.
  typedef logic [23:0] rgbT;    // red in [23:16], green in [15:8], blue in [7:0].

  // position that the raster is drawing this cycle
  typedef struct packed {
    coordT drawX;
    coordT drawY;
  } pixelPosT;

  typedef struct packed {
    logic hSync;                // active low.
    logic vSync;                // active low.
    logic videoOn;              // inside the active area.
  } syncT;

  localparam rgbT BG_COLOR = 24'hffffff;
  localparam rgbT RGB_BLACK = 24'h000000;

  // sync levels while blanked and out of reset
  localparam syncT SYNC_IDLE = '{hSync: 1'b1, vSync: 1'b1, videoOn: 1'b0};

endpackage

/* source/zombieRenderTop.sv */
module zombieRenderTop
  import videoPkg::*;
  import spritePkg::*;
#(
  parameter int H_ACTIVE = 640,
  parameter int H_FRONT = 16,
  parameter int H_SYNC = 96,
  parameter int H_BACK = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FRONT = 10,
  parameter int V_SYNC = 2,
  parameter int V_BACK = 33,
  parameter int NUM_ZOMBIES = 3
)
(
  input logic Clk,
  input logic rst,
  input zombieT [NUM_ZOMBIES-1:0] zombies,
  input logic spriteWe,
  input spriteAddrT spriteWrAddr,
  input rgbT spriteWrData,
  output rgbT vgaRgb,
  output syncT vgaSync
);

  pixelPosT pixelPos;
  syncT rawSync;
  rgbT spriteColor;
  logic isZombie;
  syncT tableSync;

  vgaTimer #(
    .H_ACTIVE(H_ACTIVE),
    .H_FRONT(H_FRONT),
    .H_SYNC(H_SYNC),
    .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE),
    .V_FRONT(V_FRONT),
    .V_SYNC(V_SYNC),
    .V_BACK(V_BACK)
  ) i_vgaTimer (
    .Clk(Clk),
    .rst(rst),
    .pixelPos(pixelPos),
    .rawSync(rawSync)
  );

  zombieSpriteTable #(
    .NUM_ZOMBIES(NUM_ZOMBIES)
  ) i_zombieSpriteTable (
    .Clk(Clk),
    .rst(rst),
    .pixelPos(pixelPos),
    .rawSync(rawSync),
    .zombies(zombies),
    .spriteWe(spriteWe),
    .spriteWrAddr(spriteWrAddr),
    .spriteWrData(spriteWrData),
    .spriteColor(spriteColor),
    .isZombie(isZombie),
    .tableSync(tableSync)
  );

  pixelColorMapper i_pixelColorMapper (
    .Clk(Clk),
    .rst(rst),
    .spriteColor(spriteColor),
    .isZombie(isZombie),
    .tableSync(tableSync),
    .vgaRgb(vgaRgb),
    .vgaSync(vgaSync)
  );

endmodule

/* source/zombieSpriteTable.sv */
module zombieSpriteTable
  import videoPkg::*;
  import spritePkg::*;
#(
  parameter int NUM_ZOMBIES = 3
)
(
  input logic Clk,
  input logic rst,
  input pixelPosT pixelPos,
  input syncT rawSync,
  input zombieT [NUM_ZOMBIES-1:0] zombies,
  input logic spriteWe,
  input spriteAddrT spriteWrAddr,
  input rgbT spriteWrData,
  output rgbT spriteColor,
  output logic isZombie,
  output syncT tableSync
);

  logic [NUM_ZOMBIES-1:0] hitVec;
  coordT colDiff [NUM_ZOMBIES];
  coordT rowDiff [NUM_ZOMBIES];

  logic anyHit;
  coordT selCol;
  coordT selRow;
  faceT selFace;
  spriteAddrT rdAddr;

  // offsets stay small only when the pixel is at or past the corner
  for (genvar i = 0; i < NUM_ZOMBIES; i++)
  begin : gHit
    assign colDiff[i] = pixelPos.drawX - zombies[i].posX;
    assign rowDiff[i] = pixelPos.drawY - zombies[i].posY;
    assign hitVec[i] = (pixelPos.drawX >= zombies[i].posX) &&
                       (pixelPos.drawY >= zombies[i].posY) &&
                       (colDiff[i] < coordT'(SPRITE_SIZE)) &&
                       (rowDiff[i] < coordT'(SPRITE_SIZE));
  end

  // walk from the top index down so the lowest hit is taken last
  always_comb
  begin
    anyHit = 1'b0;
    selCol = '0;
    selRow = '0;
    selFace = FACE_UP;
    for (int i = NUM_ZOMBIES - 1; i >= 0; i--)
    begin
      if (hitVec[i])
      begin
        anyHit = 1'b1;
        selCol = colDiff[i];
        selRow = rowDiff[i];
        selFace = zombies[i].face;
      end
    end
  end

  assign rdAddr = {selFace, spriteOffT'(selRow), spriteOffT'(selCol)};

  spriteRam i_spriteRam (
    .Clk(Clk),
    .we(spriteWe),
    .wrAddr(spriteWrAddr),
    .wrData(spriteWrData),
    .rdAddr(rdAddr),
    .rdData(spriteColor)
  );

  // hit flag and sync follow the memory read by one cycle
  always_ff @(posedge Clk)
  begin
    if (rst)
    begin
      isZombie <= 1'b0;
      tableSync <= SYNC_IDLE;
    end
    else
    begin
      isZombie <= anyHit;
      tableSync <= rawSync;
    end
  end

  // the word shown for a hit was read from inside the sprite box
  offsetRangeA: assert property (@(posedge Clk) disable iff (rst)
    isZombie |-> (($past(selRow) < coordT'(SPRITE_SIZE)) &&
                  ($past(selCol) < coordT'(SPRITE_SIZE))));

endmodule

/* verilog.f */
source/videoPkg.sv
source/spritePkg.sv
source/vgaTimer.sv
source/spriteRam.sv
source/zombieSpriteTable.sv
source/pixelColorMapper.sv
source/zombieRenderTop.sv
dv/zombieRenderTb.sv
